// ==== Bender.yml ====
package:
  name: csr_exc

sources:
  - files:
      - design/csr_pkg.sv
      - design/csr_exc_state.sv
      - design/csr_int_ctrl.sv
      - design/csr_timer.sv
      - design/csr_scratch.sv
      - design/csr_read_mux.sv
      - design/csr_top.sv
  - target: test
    files:
      - test/csr_properties.sv
      - test/csr_tb.sv

// ==== design/csr_exc_state.sv ====
`timescale 1ns/100ps

module csr_exc_state (
   input  logic                clk,
   input  logic                resetn,
   input  csr_pkg::csr_wr_t    csr_wr,
   input  csr_pkg::exc_event_t exc,
   output csr_pkg::csr_word_u  crmd,
   output csr_pkg::csr_word_u  prmd,
   output logic [31:0]         era,
   output logic [31:0]         eentry,
   output logic [31:0]         badv,
   output logic [5:0]          ecode,
   output logic [8:0]          esubcode,
   output logic                crmd_ie
);
   import csr_pkg::*;

   logic [1:0]  plv_q;
   logic        ie_q;
   logic [1:0]  pplv_q;
   logic        pie_q;
   logic [25:0] eentry_va_q;
   logic        wr_crmd;
   logic        wr_prmd;
   logic        wr_era;
   logic        wr_eentry;
   logic        wr_badv;
   logic        addr_err;
   logic        badv_from_pc;
   logic [31:0] eentry_wr;
   csr_word_u   crmd_wr;
   csr_word_u   prmd_wr;

   always_comb begin
      crmd = '0;
      crmd.crmd.plv = plv_q;
      crmd.crmd.ie = ie_q;
      prmd = '0;
      prmd.prmd.pplv = pplv_q;
      prmd.prmd.pie = pie_q;
   end

   assign crmd_ie = ie_q;
   assign eentry = {eentry_va_q, 6'd0};

   assign wr_crmd = csr_wr.we && (csr_wr.num == CSR_CRMD);
   assign wr_prmd = csr_wr.we && (csr_wr.num == CSR_PRMD);
   assign wr_era = csr_wr.we && (csr_wr.num == CSR_ERA);
   assign wr_eentry = csr_wr.we && (csr_wr.num == CSR_EENTRY);
   assign wr_badv = csr_wr.we && (csr_wr.num == CSR_BADV);

   assign crmd_wr.raw = csr_merge(crmd.raw, csr_wr);
   assign prmd_wr.raw = csr_merge(prmd.raw, csr_wr);
   assign eentry_wr = csr_merge(eentry, csr_wr);

   assign addr_err = (exc.ecode == ECODE_ADE) || (exc.ecode == ECODE_ALE);
   // Instruction fetch ADE reports the faulting pc
   assign badv_from_pc = (exc.ecode == ECODE_ADE) && (exc.esubcode == 9'd0);

   always_ff @(posedge clk) begin
      if (!resetn) begin
         plv_q <= 2'd0;
         ie_q <= 1'b0;
         pplv_q <= 2'd0;
         pie_q <= 1'b0;
      end else if (exc.ex) begin
         plv_q <= 2'd0;
         ie_q <= 1'b0;
         pplv_q <= plv_q;
         pie_q <= ie_q;
      end else if (exc.ertn) begin
         plv_q <= pplv_q;
         ie_q <= pie_q;
      end else begin
         if (wr_crmd) begin
            plv_q <= crmd_wr.crmd.plv;
            ie_q <= crmd_wr.crmd.ie;
         end
         if (wr_prmd) begin
            pplv_q <= prmd_wr.prmd.pplv;
            pie_q <= prmd_wr.prmd.pie;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!resetn) begin
         era <= 32'd0;
         badv <= 32'd0;
         ecode <= 6'd0;
         esubcode <= 9'd0;
         eentry_va_q <= 26'd0;
      end else if (exc.ex) begin
         era <= exc.pc;
         ecode <= exc.ecode;
         esubcode <= exc.esubcode;
         if (addr_err) begin
            badv <= badv_from_pc ? exc.pc : exc.vaddr;
         end
      end else if (!exc.ertn) begin
         if (wr_era) begin
            era <= csr_merge(era, csr_wr);
         end
         if (wr_badv) begin
            badv <= csr_merge(badv, csr_wr);
         end
         if (wr_eentry) begin
            eentry_va_q <= eentry_wr[31:6];
         end
      end
   end

endmodule

// ==== design/csr_int_ctrl.sv ====
`timescale 1ns/100ps

module csr_int_ctrl (
   input  logic             clk,
   input  logic             resetn,
   input  csr_pkg::csr_wr_t csr_wr,
   input  logic [7:0]       hw_int,
   input  logic             ipi_int,
   input  logic             timer_zero,
   input  logic             crmd_ie,
   output logic [31:0]      ecfg,
   output logic [12:0]      estat_is,
   output logic             has_int
);
   import csr_pkg::*;

   logic [12:0] lie_q;
   logic [1:0]  is_sw_q;
   logic [7:0]  is_hw_q;
   logic        is_ti_q;
   logic        is_ipi_q;
   logic        wr_ecfg;
   logic        wr_estat;
   logic        ticlr_clr;
   logic [31:0] ecfg_wr;
   csr_word_u   estat_wr;

   assign ecfg = {19'd0, lie_q};
   assign estat_is = {is_ipi_q, is_ti_q, 1'b0, is_hw_q, is_sw_q};

   assign wr_ecfg = csr_wr.we && (csr_wr.num == CSR_ECFG);
   assign wr_estat = csr_wr.we && (csr_wr.num == CSR_ESTAT);
   assign ticlr_clr = csr_wr.we && (csr_wr.num == CSR_TICLR) &&
                      csr_wr.wmask[TICLR_CLR_BIT] && csr_wr.wvalue[TICLR_CLR_BIT];

   assign ecfg_wr = csr_merge(ecfg, csr_wr);
   assign estat_wr.raw = csr_merge({19'd0, estat_is}, csr_wr);

   always_ff @(posedge clk) begin
      if (!resetn) begin
         lie_q <= 13'd0;
         is_sw_q <= 2'd0;
         is_hw_q <= 8'd0;
         is_ti_q <= 1'b0;
         is_ipi_q <= 1'b0;
      end else begin
         if (wr_ecfg) begin
            lie_q <= ecfg_wr[12:0] & ECFG_LIE_MASK;
         end
         if (wr_estat) begin
            is_sw_q <= estat_wr.estat.is[1:0];
         end
         is_hw_q <= hw_int;
         is_ipi_q <= ipi_int;
         // Timer expiry wins over a clear in the same cycle
         if (timer_zero) begin
            is_ti_q <= 1'b1;
         end else if (ticlr_clr) begin
            is_ti_q <= 1'b0;
         end
      end
   end

   assign has_int = (|(estat_is & lie_q)) & crmd_ie;

endmodule

// ==== design/csr_pkg.sv ====
package csr_pkg;

   localparam int CSR_NUM_W = 14;

   typedef logic [CSR_NUM_W-1:0] csr_num_t;

   // CSR address map
   localparam csr_num_t CSR_CRMD   = 14'h000;
   localparam csr_num_t CSR_PRMD   = 14'h001;
   localparam csr_num_t CSR_ECFG   = 14'h004;
   localparam csr_num_t CSR_ESTAT  = 14'h005;
   localparam csr_num_t CSR_ERA    = 14'h006;
   localparam csr_num_t CSR_BADV   = 14'h007;
   localparam csr_num_t CSR_EENTRY = 14'h00c;
   localparam csr_num_t CSR_SAVE0  = 14'h030;
   localparam csr_num_t CSR_SAVE1  = 14'h031;
   localparam csr_num_t CSR_SAVE2  = 14'h032;
   localparam csr_num_t CSR_SAVE3  = 14'h033;
   localparam csr_num_t CSR_TID    = 14'h040;
   localparam csr_num_t CSR_TCFG   = 14'h041;
   localparam csr_num_t CSR_TVAL   = 14'h042;
   localparam csr_num_t CSR_TICLR  = 14'h044;

   // Address error exception codes
   localparam logic [5:0] ECODE_ADE = 6'h08;
   localparam logic [5:0] ECODE_ALE = 6'h09;

   // LIE bit 10 has no interrupt source
   localparam logic [12:0] ECFG_LIE_MASK = 13'h1bff;

   localparam int TICLR_CLR_BIT = 0;

   // Counter value of a stopped timer
   localparam logic [31:0] TIMER_IDLE = 32'hffff_ffff;

   typedef struct packed {
      logic [28:0] rsvd;
      logic        ie;
      logic [1:0]  plv;
   } crmd_view_t;

   typedef struct packed {
      logic [28:0] rsvd;
      logic        pie;
      logic [1:0]  pplv;
   } prmd_view_t;

   typedef struct packed {
      logic        rsvd31;
      logic [8:0]  esubcode;
      logic [5:0]  ecode;
      logic [2:0]  zero;
      logic [12:0] is;
   } estat_view_t;

   typedef struct packed {
      logic [29:0] initval;
      logic        periodic;
      logic        en;
   } tcfg_view_t;

   typedef union packed {
      logic [31:0] raw;
      crmd_view_t  crmd;
      prmd_view_t  prmd;
      estat_view_t estat;
      tcfg_view_t  tcfg;
   } csr_word_u;

   typedef struct packed {
      logic        we;
      csr_num_t    num;
      logic [31:0] wmask;
      logic [31:0] wvalue;
   } csr_wr_t;

   typedef struct packed {
      logic        ex;
      logic        ertn;
      logic [5:0]  ecode;
      logic [8:0]  esubcode;
      logic [31:0] pc;
      logic [31:0] vaddr;
   } exc_event_t;

   // Masked bits from the write value, the rest from the old word
   function automatic logic [31:0] csr_merge(input logic [31:0] old, input csr_wr_t wr);
      return (wr.wmask & wr.wvalue) | (~wr.wmask & old);
   endfunction

endpackage

// ==== design/csr_read_mux.sv ====
`timescale 1ns/100ps

module csr_read_mux (
   input  csr_pkg::csr_num_t  rd_num,
   input  csr_pkg::csr_word_u crmd,
   input  csr_pkg::csr_word_u prmd,
   input  logic [31:0]        ecfg,
   input  logic [12:0]        estat_is,
   input  logic [5:0]         ecode,
   input  logic [8:0]         esubcode,
   input  logic [31:0]        era,
   input  logic [31:0]        badv,
   input  logic [31:0]        eentry,
   input  logic [3:0][31:0]   save,
   input  logic [31:0]        tid,
   input  csr_pkg::csr_word_u tcfg,
   input  logic [31:0]        tval,
   output logic [31:0]        rd_value
);
   import csr_pkg::*;

   csr_word_u estat;

   always_comb begin
      estat = '0;
      estat.estat.is = estat_is;
      estat.estat.ecode = ecode;
      estat.estat.esubcode = esubcode;
   end

   always_comb begin
      case (rd_num)
         CSR_CRMD:   rd_value = crmd.raw;
         CSR_PRMD:   rd_value = prmd.raw;
         CSR_ECFG:   rd_value = ecfg;
         CSR_ESTAT:  rd_value = estat.raw;
         CSR_ERA:    rd_value = era;
         CSR_BADV:   rd_value = badv;
         CSR_EENTRY: rd_value = eentry;
         CSR_SAVE0:  rd_value = save[0];
         CSR_SAVE1:  rd_value = save[1];
         CSR_SAVE2:  rd_value = save[2];
         CSR_SAVE3:  rd_value = save[3];
         CSR_TID:    rd_value = tid;
         CSR_TCFG:   rd_value = tcfg.raw;
         CSR_TVAL:   rd_value = tval;
         // TICLR is write-only
         default:    rd_value = 32'd0;
      endcase
   end

endmodule

// ==== design/csr_scratch.sv ====
`timescale 1ns/100ps

module csr_scratch (
   input  logic             clk,
   input  logic             resetn,
   input  csr_pkg::csr_wr_t csr_wr,
   input  logic [31:0]      coreid,
   output logic [3:0][31:0] save,
   output logic [31:0]      tid
);
   import csr_pkg::*;

   logic [3:0] wr_save;
   logic       wr_tid;

   always_comb begin
      for (int i = 0; i < 4; i++) begin
         wr_save[i] = csr_wr.we && (csr_wr.num == csr_num_t'(CSR_SAVE0 + i));
      end
   end

   assign wr_tid = csr_wr.we && (csr_wr.num == CSR_TID);

   always_ff @(posedge clk) begin
      for (int i = 0; i < 4; i++) begin
         if (!resetn) begin
            save[i] <= 32'd0;
         end else if (wr_save[i]) begin
            save[i] <= csr_merge(save[i], csr_wr);
         end
      end
   end

   // Core number is captured while reset is held
   always_ff @(posedge clk) begin
      if (!resetn) begin
         tid <= coreid;
      end else if (wr_tid) begin
         tid <= csr_merge(tid, csr_wr);
      end
   end

endmodule

// ==== design/csr_timer.sv ====
`timescale 1ns/100ps

module csr_timer (
   input  logic               clk,
   input  logic               resetn,
   input  csr_pkg::csr_wr_t   csr_wr,
   output csr_pkg::csr_word_u tcfg,
   output logic [31:0]        tval,
   output logic               timer_zero
);
   import csr_pkg::*;

   logic      wr_tcfg;
   logic      tval_running;
   csr_word_u tcfg_wr;

   assign wr_tcfg = csr_wr.we && (csr_wr.num == CSR_TCFG);

   // TCFG value as it will be after this write
   assign tcfg_wr.raw = csr_merge(tcfg.raw, csr_wr);

   assign tval_running = tcfg.tcfg.en && (tval != TIMER_IDLE);
   assign timer_zero = (tval == 32'd0);

   always_ff @(posedge clk) begin
      if (!resetn) begin
         tcfg <= '0;
      end else if (wr_tcfg) begin
         tcfg <= tcfg_wr;
      end
   end

   always_ff @(posedge clk) begin
      if (!resetn) begin
         tval <= TIMER_IDLE;
      end else if (wr_tcfg && tcfg_wr.tcfg.en) begin
         tval <= {tcfg_wr.tcfg.initval, 2'b00};
      end else if (tval_running) begin
         if (timer_zero) begin
            // Periodic reload, otherwise stop
            tval <= tcfg.tcfg.periodic ? {tcfg.tcfg.initval, 2'b00} : TIMER_IDLE;
         end else begin
            tval <= tval - 32'd1;
         end
      end
   end

endmodule

// ==== design/csr_top.sv ====
`timescale 1ns/100ps

module csr_top (
   input  logic                clk,
   input  logic                resetn,
   input  csr_pkg::csr_wr_t    csr_wr,
   input  csr_pkg::csr_num_t   rd_num,
   input  csr_pkg::exc_event_t exc,
   input  logic [7:0]          hw_int,
   input  logic                ipi_int,
   input  logic [31:0]         coreid,
   output logic [31:0]         rd_value,
   output logic [31:0]         ex_entry,
   output logic [31:0]         era,
   output logic                has_int
);
   import csr_pkg::*;

   csr_word_u        crmd;
   csr_word_u        prmd;
   csr_word_u        tcfg;
   logic [31:0]      badv;
   logic [5:0]       ecode;
   logic [8:0]       esubcode;
   logic             crmd_ie;
   logic [31:0]      ecfg;
   logic [12:0]      estat_is;
   logic [31:0]      tval;
   logic             timer_zero;
   logic [3:0][31:0] save;
   logic [31:0]      tid;

   csr_exc_state u_exc_state (
      .clk      (clk),
      .resetn   (resetn),
      .csr_wr   (csr_wr),
      .exc      (exc),
      .crmd     (crmd),
      .prmd     (prmd),
      .era      (era),
      .eentry   (ex_entry),
      .badv     (badv),
      .ecode    (ecode),
      .esubcode (esubcode),
      .crmd_ie  (crmd_ie)
   );

   csr_int_ctrl u_int_ctrl (
      .clk        (clk),
      .resetn     (resetn),
      .csr_wr     (csr_wr),
      .hw_int     (hw_int),
      .ipi_int    (ipi_int),
      .timer_zero (timer_zero),
      .crmd_ie    (crmd_ie),
      .ecfg       (ecfg),
      .estat_is   (estat_is),
      .has_int    (has_int)
   );

   csr_timer u_timer (
      .clk        (clk),
      .resetn     (resetn),
      .csr_wr     (csr_wr),
      .tcfg       (tcfg),
      .tval       (tval),
      .timer_zero (timer_zero)
   );

   csr_scratch u_scratch (
      .clk    (clk),
      .resetn (resetn),
      .csr_wr (csr_wr),
      .coreid (coreid),
      .save   (save),
      .tid    (tid)
   );

   csr_read_mux u_read_mux (
      .rd_num   (rd_num),
      .crmd     (crmd),
      .prmd     (prmd),
      .ecfg     (ecfg),
      .estat_is (estat_is),
      .ecode    (ecode),
      .esubcode (esubcode),
      .era      (era),
      .badv     (badv),
      .eentry   (ex_entry),
      .save     (save),
      .tid      (tid),
      .tcfg     (tcfg),
      .tval     (tval),
      .rd_value (rd_value)
   );

endmodule

// ==== tb.f ====
design/csr_pkg.sv
design/csr_exc_state.sv
design/csr_int_ctrl.sv
design/csr_timer.sv
design/csr_scratch.sv
design/csr_read_mux.sv
design/csr_top.sv
test/csr_properties.sv
test/csr_tb.sv

// ==== test/csr_properties.sv ====
`timescale 1ns/100ps

module csr_properties (
   input  logic               clk,
   input  logic               resetn,
   input  csr_pkg::csr_wr_t   csr_wr,
   input  csr_pkg::csr_word_u tcfg,
   input  logic [31:0]        tval,
   input  logic               crmd_ie,
   input  logic               has_int
);
   import csr_pkg::*;

   int   fail_count = 0;
   logic tcfg_wr;

   assign tcfg_wr = csr_wr.we && (csr_wr.num == CSR_TCFG);

   assert property (@(posedge clk) disable iff (!resetn) has_int |-> crmd_ie)
      else begin
         fail_count++;
         $error("has_int high while CRMD.IE is clear");
      end

   // First cycle out of reset
   assert property (@(posedge clk) $rose(resetn) |-> !has_int)
      else begin
         fail_count++;
         $error("has_int high right after reset");
      end

   assert property (@(posedge clk) disable iff (!resetn)
                    (!tcfg.tcfg.en && !tcfg_wr) |=> $stable(tval))
      else begin
         fail_count++;
         $error("TVAL changed while the timer is disabled");
      end

endmodule

// ==== test/csr_tb.sv ====
`timescale 1ns/100ps

module csr_tb;
   import csr_pkg::*;

   localparam int RST_CYC = 8;
   localparam int N_WR = 300;
   localparam int N_EXC = 40;
   localparam int N_ERTN = 30;
   localparam int N_INT = 40;
   localparam int N_TMR = 6;
   // Sum of all test lengths plus a margin
   localparam int MAX_CYCLES = RST_CYC + N_WR + 16 + N_EXC * 6 + N_ERTN * 2 + N_INT * 3
                               + 2 + N_TMR * 72 + 100;

   logic        clk = 1'b0;
   logic        resetn;
   csr_wr_t     csr_wr;
   csr_num_t    rd_num;
   exc_event_t  exc;
   logic [7:0]  hw_int;
   logic        ipi_int;
   logic [31:0] coreid;
   logic [31:0] rd_value;
   logic [31:0] ex_entry;
   logic [31:0] era;
   logic        has_int;

   logic [31:0] lfsr_q = 32'd32;
   string       test_name;
   int          cycle_count = 0;

   // Reference model state
   logic [1:0]  m_plv;
   logic        m_ie;
   logic [1:0]  m_pplv;
   logic        m_pie;
   logic [31:0] m_era;
   logic [31:0] m_badv;
   logic [31:0] m_eentry;
   logic [5:0]  m_ecode;
   logic [8:0]  m_esub;
   logic [12:0] m_lie;
   logic [12:0] m_is;
   csr_word_u   m_tcfg;
   logic [31:0] m_tval;
   logic [31:0] m_save [4];
   logic [31:0] m_tid;

   csr_num_t csr_list [15] = '{CSR_CRMD, CSR_PRMD, CSR_ECFG, CSR_ESTAT, CSR_ERA, CSR_BADV,
                               CSR_EENTRY, CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3,
                               CSR_TID, CSR_TCFG, CSR_TVAL, CSR_TICLR};
   csr_num_t exc_reads [4] = '{CSR_PRMD, CSR_ESTAT, CSR_BADV, CSR_ERA};

   always #20 clk = ~clk;

   csr_top UUT (
      .clk      (clk),
      .resetn   (resetn),
      .csr_wr   (csr_wr),
      .rd_num   (rd_num),
      .exc      (exc),
      .hw_int   (hw_int),
      .ipi_int  (ipi_int),
      .coreid   (coreid),
      .rd_value (rd_value),
      .ex_entry (ex_entry),
      .era      (era),
      .has_int  (has_int)
   );

   bind csr_top csr_properties u_props (
      .clk     (clk),
      .resetn  (resetn),
      .csr_wr  (csr_wr),
      .tcfg    (tcfg),
      .tval    (tval),
      .crmd_ie (crmd_ie),
      .has_int (has_int)
   );

   // Feedback taps of x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
         lfsr_q = {lfsr_q[30:0], fb};
         r = {r[30:0], fb};
      end
      return r;
   endfunction

   function automatic logic [31:0] write_bits(input logic [31:0] old, input logic [31:0] mask,
                                              input logic [31:0] value);
      return (old & ~mask) | (value & mask);
   endfunction

   function automatic csr_word_u expected_read(input csr_num_t num);
      csr_word_u w;
      w.raw = '0;
      case (num)
         CSR_CRMD: begin
            w.crmd.plv = m_plv;
            w.crmd.ie = m_ie;
         end
         CSR_PRMD: begin
            w.prmd.pplv = m_pplv;
            w.prmd.pie = m_pie;
         end
         CSR_ESTAT: begin
            w.estat.is = m_is;
            w.estat.ecode = m_ecode;
            w.estat.esubcode = m_esub;
         end
         CSR_ECFG:   w.raw = {19'd0, m_lie};
         CSR_ERA:    w.raw = m_era;
         CSR_BADV:   w.raw = m_badv;
         CSR_EENTRY: w.raw = m_eentry;
         CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3: w.raw = m_save[num[1:0]];
         CSR_TID:    w.raw = m_tid;
         CSR_TCFG:   w = m_tcfg;
         CSR_TVAL:   w.raw = m_tval;
         default:    w.raw = '0;
      endcase
      return w;
   endfunction

   function automatic logic expect_has_int();
      return (|(m_is & m_lie)) & m_ie;
   endfunction

   task automatic model_reset();
      m_plv = '0;
      m_ie = 1'b0;
      m_pplv = '0;
      m_pie = 1'b0;
      m_era = '0;
      m_badv = '0;
      m_eentry = '0;
      m_ecode = '0;
      m_esub = '0;
      m_lie = '0;
      m_is = '0;
      m_tcfg = '0;
      m_tval = TIMER_IDLE;
      m_save = '{default: 32'd0};
      m_tid = coreid;
   endtask

   task automatic model_clock();
      logic [31:0] w;
      logic        zero;
      logic        running;
      logic        ticlr;
      logic        exc_wr_ok;
      zero = (m_tval == 32'd0);
      running = m_tcfg.tcfg.en && (m_tval != TIMER_IDLE);
      ticlr = csr_wr.we && (csr_wr.num == CSR_TICLR) && csr_wr.wmask[0] && csr_wr.wvalue[0];
      // Exception and ertn take precedence over writes to the exception registers
      exc_wr_ok = !exc.ex && !exc.ertn;
      if (running) begin
         if (!zero) begin
            m_tval = m_tval - 32'd1;
         end else begin
            m_tval = m_tcfg.tcfg.periodic ? {m_tcfg.tcfg.initval, 2'b00} : TIMER_IDLE;
         end
      end
      // Expiry beats a clear
      if (zero) begin
         m_is[11] = 1'b1;
      end else if (ticlr) begin
         m_is[11] = 1'b0;
      end
      m_is[9:2] = hw_int;
      m_is[12] = ipi_int;
      if (exc.ex) begin
         m_pplv = m_plv;
         m_pie = m_ie;
         m_plv = '0;
         m_ie = 1'b0;
         m_era = exc.pc;
         m_ecode = exc.ecode;
         m_esub = exc.esubcode;
         if (exc.ecode == ECODE_ADE && exc.esubcode == 9'd0) begin
            m_badv = exc.pc;
         end else if (exc.ecode == ECODE_ADE || exc.ecode == ECODE_ALE) begin
            m_badv = exc.vaddr;
         end
      end else if (exc.ertn) begin
         m_plv = m_pplv;
         m_ie = m_pie;
      end
      if (csr_wr.we) begin
         case (csr_wr.num)
            CSR_CRMD: if (exc_wr_ok) begin
               w = write_bits({29'd0, m_ie, m_plv}, csr_wr.wmask, csr_wr.wvalue);
               m_plv = w[1:0];
               m_ie = w[2];
            end
            CSR_PRMD: if (exc_wr_ok) begin
               w = write_bits({29'd0, m_pie, m_pplv}, csr_wr.wmask, csr_wr.wvalue);
               m_pplv = w[1:0];
               m_pie = w[2];
            end
            CSR_ECFG: begin
               w = write_bits({19'd0, m_lie}, csr_wr.wmask, csr_wr.wvalue);
               m_lie = w[12:0] & ECFG_LIE_MASK;
            end
            CSR_ESTAT: begin
               w = write_bits({19'd0, m_is}, csr_wr.wmask, csr_wr.wvalue);
               m_is[1:0] = w[1:0];
            end
            CSR_ERA: if (exc_wr_ok) begin
               m_era = write_bits(m_era, csr_wr.wmask, csr_wr.wvalue);
            end
            CSR_BADV: if (exc_wr_ok) begin
               m_badv = write_bits(m_badv, csr_wr.wmask, csr_wr.wvalue);
            end
            CSR_EENTRY: if (exc_wr_ok) begin
               m_eentry = write_bits(m_eentry, csr_wr.wmask, csr_wr.wvalue) & ~32'h3f;
            end
            CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3: begin
               m_save[csr_wr.num[1:0]] = write_bits(m_save[csr_wr.num[1:0]], csr_wr.wmask,
                                                    csr_wr.wvalue);
            end
            CSR_TID:    m_tid = write_bits(m_tid, csr_wr.wmask, csr_wr.wvalue);
            CSR_TCFG: begin
               m_tcfg.raw = write_bits(m_tcfg.raw, csr_wr.wmask, csr_wr.wvalue);
               if (m_tcfg.tcfg.en) begin
                  m_tval = {m_tcfg.tcfg.initval, 2'b00};
               end
            end
            default: ;
         endcase
      end
   endtask

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Simulation finished: FAIL");
      $fatal(1, "Run stopped at first failure");
   endtask

   task automatic check_word(input string what, input csr_word_u expected,
                             input csr_word_u actual);
      if (actual !== expected) begin
         fail_run($sformatf("Mismatch in %s, %s: expected %08h, actual %08h",
                            test_name, what, expected.raw, actual.raw));
      end
   endtask

   task automatic check_bit(input string what, input logic expected, input logic actual);
      if (actual !== expected) begin
         fail_run($sformatf("Mismatch in %s, %s: expected %b, actual %b",
                            test_name, what, expected, actual));
      end
   endtask

   // Model steps at the rising edge and outputs are checked at the falling edge
   task automatic tick();
      @(posedge clk);
      if (!resetn) begin
         model_reset();
      end else begin
         model_clock();
      end
      @(negedge clk);
      if (UUT.u_props.fail_count != 0) begin
         fail_run($sformatf("A bound assertion on the DUT failed during %s", test_name));
      end
      check_word($sformatf("read of CSR 0x%0h", rd_num), expected_read(rd_num), rd_value);
      check_word("era output", m_era, era);
      check_word("ex_entry output", m_eentry, ex_entry);
      check_bit("has_int", expect_has_int(), has_int);
   endtask

   task automatic drive_write(input csr_num_t num, input logic [31:0] mask,
                              input logic [31:0] value);
      csr_wr.we = 1'b1;
      csr_wr.num = num;
      csr_wr.wmask = mask;
      csr_wr.wvalue = value;
   endtask

   task automatic clear_inputs();
      csr_wr = '0;
      exc = '0;
   endtask

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count > MAX_CYCLES) begin
         fail_run($sformatf("Timeout: run did not finish within %0d cycles", MAX_CYCLES));
      end
   end

   initial begin
      int          idx;
      logic [1:0]  sel;
      logic [31:0] initval;
      resetn = 1'b0;
      csr_wr = '0;
      exc = '0;
      hw_int = '0;
      ipi_int = 1'b0;
      rd_num = CSR_TID;
      coreid = rand_bits(32);
      test_name = "reset";
      repeat (RST_CYC) tick();
      resetn = 1'b1;

      test_name = "masked writes";
      repeat (N_WR) begin
         idx = rand_bits(4) % 15;
         drive_write(csr_list[idx], rand_bits(32), rand_bits(32));
         rd_num = csr_list[rand_bits(4) % 15];
         tick();
      end
      clear_inputs();
      foreach (csr_list[i]) begin
         rd_num = csr_list[i];
         tick();
      end
      // Unmapped address
      rd_num = 14'h3ff;
      tick();

      test_name = "exception entry";
      repeat (N_EXC) begin
         drive_write(CSR_CRMD, 32'h7, rand_bits(3));
         rd_num = CSR_CRMD;
         tick();
         clear_inputs();
         exc.ex = 1'b1;
         sel = 2'(rand_bits(2));
         exc.ecode = (sel == 2'd0) ? ECODE_ADE : (sel == 2'd1) ? ECODE_ALE : 6'(rand_bits(6));
         exc.esubcode = rand_bits(1) ? 9'd0 : 9'(rand_bits(9));
         exc.pc = rand_bits(32);
         exc.vaddr = rand_bits(32);
         tick();
         clear_inputs();
         foreach (exc_reads[i]) begin
            rd_num = exc_reads[i];
            tick();
         end
      end

      test_name = "ertn";
      repeat (N_ERTN) begin
         drive_write(CSR_PRMD, rand_bits(32), rand_bits(32));
         rd_num = CSR_PRMD;
         tick();
         clear_inputs();
         exc.ertn = 1'b1;
         rd_num = CSR_CRMD;
         tick();
         clear_inputs();
      end

      test_name = "interrupts";
      repeat (N_INT) begin
         drive_write(CSR_ECFG, 32'hffff_ffff, rand_bits(32));
         rd_num = CSR_ECFG;
         tick();
         drive_write(CSR_CRMD, 32'h4, rand_bits(32));
         hw_int = 8'(rand_bits(8));
         ipi_int = 1'(rand_bits(1));
         rd_num = CSR_ESTAT;
         tick();
         clear_inputs();
         tick();
      end
      hw_int = '0;
      ipi_int = 1'b0;

      test_name = "timer";
      // Only the timer line enabled with global enable on
      drive_write(CSR_ECFG, 32'hffff_ffff, 32'h800);
      rd_num = CSR_ECFG;
      tick();
      drive_write(CSR_CRMD, 32'h4, 32'h4);
      rd_num = CSR_ESTAT;
      tick();
      for (int r = 0; r < N_TMR; r++) begin
         initval = 32'd1 + rand_bits(3);
         drive_write(CSR_TCFG, 32'hffff_ffff, {initval[29:0], r[0], 1'b1});
         rd_num = CSR_TVAL;
         tick();
         clear_inputs();
         repeat (initval * 8 + 4) tick();
         drive_write(CSR_TICLR, 32'h1, 32'h1);
         rd_num = CSR_ESTAT;
         tick();
         drive_write(CSR_TCFG, 32'h1, 32'h0);
         tick();
         clear_inputs();
      end

      if (UUT.u_props.fail_count == 0) begin
         $display("Simulation finished: PASS");
         $finish;
      end else begin
         $display("Simulation finished: FAIL");
         $fatal(1, "Bound assertions reported errors");
      end
   end

endmodule
